// ==== files.f ====
hdl/map_pkg.sv
hdl/mmc3_regs.sv
hdl/chr_bank_map.sv
hdl/irq_mmc3.sv
hdl/map_189.sv
test/map_189_chk.sv
test/tb_map_189.sv

// ==== hdl/chr_bank_map.sv ====
`timescale 1ns/1ps

module chr_bank_map
(
	input  logic [12:0] ppu_addr,
	input  logic        chr_mode,
	input  logic [63:0] bank_dat_flat,
	input  logic        mirror_v,
	input  logic        cfg_chr_ram,
	output logic [17:0] chr_addr,
	output logic        ciram_a10
);

	import map_pkg::*;

	logic       two_kb;
	logic [2:0] bank_idx;
	logic [7:0] chr_bank;

	// The half at A12 == chr_mode uses the 2 KB banks
	assign two_kb = (ppu_addr[12] == chr_mode);

	always_comb
	begin
		if (two_kb)
			bank_idx = {2'b00, ppu_addr[11]}; // Banks 0 and 1
		else
			bank_idx = {1'b0, ppu_addr[11:10]} + 3'd2; // Banks 2 to 5
		chr_bank = bank_dat_flat[{bank_idx, 3'b000} +: 8];
		if (two_kb)
			chr_bank[0] = ppu_addr[10]; // A10 replaces the low bank bit
	end

	assign chr_addr[9:0] = ppu_addr[9:0];

	// CHR RAM only decodes the low bank bits
	assign chr_addr[17:10] = cfg_chr_ram
		? {{(8 - CHR_RAM_BITS){1'b0}}, chr_bank[CHR_RAM_BITS-1:0]}
		: chr_bank;

	assign ciram_a10 = mirror_v ? ppu_addr[10] : ppu_addr[11]; // A10 vertical, A11 horizontal

endmodule

// ==== hdl/irq_mmc3.sv ====
`timescale 1ns/1ps

module irq_mmc3
#(
	parameter int A12_FILTER = map_pkg::A12_FILTER
)
(
	input  logic        m2,
	input  logic        map_rst,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dat,
	input  logic        cpu_rw,
	input  logic        ppu_a12,
	input  logic        mmc3a,
	input  logic        ss_act,
	input  logic        ss_we,
	input  logic [7:0]  ss_addr,
	output logic        irq,
	output logic [7:0]  irq_ss_dat
);

	import map_pkg::*;

	localparam logic [7:0] FLT      = 8'(A12_FILTER);
	localparam logic [7:0] SS_LATCH = SS_IRQ_BASE;
	localparam logic [7:0] SS_CTR   = SS_IRQ_BASE + 8'd1;
	localparam logic [7:0] SS_FLAGS = SS_IRQ_BASE + 8'd2;
	localparam logic [7:0] SS_FILT  = SS_IRQ_BASE + 8'd3;

	logic [7:0]  irq_latch;
	logic [7:0]  irq_ctr;
	logic        irq_on;
	logic        irq_reload;
	logic        irq_pend;
	logic [7:0]  a12_cnt; // Low edges seen since A12 last went high
	logic [15:0] reg_addr;
	logic        a12_rise;
	logic [7:0]  ctr_next;
	logic        ctr_hit;

	assign reg_addr = {cpu_addr[15:13], 12'd0, cpu_addr[0]};
	assign a12_rise = ppu_a12 && (a12_cnt >= FLT);
	assign ctr_next = (irq_ctr == 8'd0 || irq_reload) ? irq_latch : irq_ctr - 8'd1;

	// MMC3A only fires when the count actually reached zero
	assign ctr_hit = (ctr_next == 8'd0) && (!mmc3a || irq_ctr != 8'd0 || irq_reload);

	assign irq = irq_pend;

	always_ff @(negedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we)
			begin
				case (ss_addr)
					SS_LATCH: irq_latch <= cpu_dat;
					SS_CTR:   irq_ctr <= cpu_dat;
					SS_FLAGS:
					begin
						irq_on <= cpu_dat[0];
						irq_reload <= cpu_dat[1];
						irq_pend <= cpu_dat[2];
					end
					SS_FILT:  a12_cnt <= cpu_dat;
					default: ;
				endcase
			end
		end
		else if (map_rst)
		begin
			irq_latch <= 8'd0;
			irq_ctr <= 8'd0;
			irq_on <= 1'b0;
			irq_reload <= 1'b0;
			irq_pend <= 1'b0;
			a12_cnt <= 8'd0;
		end
		else
		begin
			if (ppu_a12)
				a12_cnt <= 8'd0;
			else if (a12_cnt < FLT)
				a12_cnt <= a12_cnt + 8'd1; // Saturates at the filter length
			if (a12_rise)
			begin
				irq_ctr <= ctr_next;
				irq_reload <= 1'b0;
				if (ctr_hit && irq_on)
					irq_pend <= 1'b1;
			end
			// CPU writes come last so they win over a rise on the same edge
			if (!cpu_rw)
			begin
				case (reg_addr)
					REG_IRQ_LATCH:  irq_latch <= cpu_dat;
					REG_IRQ_RELOAD:
					begin
						irq_ctr <= 8'd0;
						irq_reload <= 1'b1;
					end
					REG_IRQ_OFF:
					begin
						irq_on <= 1'b0;
						irq_pend <= 1'b0; // Also acknowledges
					end
					REG_IRQ_ON:     irq_on <= 1'b1;
					default: ;
				endcase
			end
		end
	end

	always_comb
	begin
		case (ss_addr)
			SS_LATCH: irq_ss_dat = irq_latch;
			SS_CTR:   irq_ss_dat = irq_ctr;
			SS_FLAGS: irq_ss_dat = {5'd0, irq_pend, irq_reload, irq_on};
			SS_FILT:  irq_ss_dat = a12_cnt;
			default:  irq_ss_dat = 8'hff;
		endcase
	end

endmodule

// ==== hdl/map_189.sv ====
`timescale 1ns/1ps

module map_189
#(
	parameter int A12_FILTER = map_pkg::A12_FILTER
)
(
	input  logic        m2,
	input  logic        map_rst,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dat,
	input  logic        cpu_rw,
	input  logic [13:0] ppu_addr,
	input  logic        ppu_oe,
	input  logic        ppu_we,
	input  logic        cfg_chr_ram,
	input  logic        cfg_mir_v,
	input  logic [3:0]  map_sub,
	input  logic [7:0]  map_idx,
	input  logic        ss_act,
	input  logic        ss_we,
	input  logic [7:0]  ss_addr,
	output logic [18:0] prg_addr,
	output logic        prg_oe,
	output logic        rom_ce,
	output logic [17:0] chr_addr,
	output logic        chr_oe,
	output logic        chr_ce,
	output logic        chr_we,
	output logic        ciram_a10,
	output logic        ciram_ce,
	output logic        irq,
	output logic [7:0]  ss_rdat
);

	import map_pkg::*;

	logic [PRG_PAGE_W-1:0] prg_page;
	logic [7:0]            bank_sel;
	logic [63:0]           bank_dat_flat;
	logic                  mirror_v;
	logic [7:0]            mmc_ss_dat;
	logic [7:0]            irq_ss_dat;
	logic                  mmc3a;
	logic                  prg_win;

	assign mmc3a = (map_sub == 4'd4);
	assign prg_win = (cpu_addr >= PRG_WIN_LO) && (cpu_addr < PRG_WIN_HI);

	// 32 KB page register in the low CPU window
	always_ff @(negedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we && ss_addr == SS_PRG)
				prg_page <= cpu_dat[PRG_PAGE_W-1:0];
		end
		else if (map_rst)
			prg_page <= PRG_RESET;
		else if (!cpu_rw && prg_win)
			prg_page <= cpu_dat[7:4] | cpu_dat[3:0]; // Nibbles ORed into the page
	end

	assign prg_addr[14:0] = cpu_addr[14:0];
	assign prg_addr[18:15] = prg_page;
	assign prg_oe = cpu_rw;
	assign rom_ce = cpu_addr[15];

	assign ciram_ce = !ppu_addr[13]; // Pattern tables below 2000h
	assign chr_ce = ciram_ce;
	assign chr_oe = !ppu_oe;
	assign chr_we = cfg_chr_ram && !ppu_we; // PPU write strobe is active low

	always_comb
	begin
		if (ss_addr <= SS_RAM_CTRL)
			ss_rdat = mmc_ss_dat; // Banks, select and control
		else if (ss_addr[7:3] == SS_IRQ_BASE[7:3])
			ss_rdat = irq_ss_dat;
		else if (ss_addr == SS_PRG)
			ss_rdat = {{(8 - PRG_PAGE_W){1'b0}}, prg_page};
		else if (ss_addr == SS_MAP_IDX)
			ss_rdat = map_idx;
		else
			ss_rdat = 8'hff;
	end

	mmc3_regs mmc3_regs_i
	(
		.m2            (m2),
		.map_rst       (map_rst),
		.cpu_addr      (cpu_addr),
		.cpu_dat       (cpu_dat),
		.cpu_rw        (cpu_rw),
		.cfg_mir_v     (cfg_mir_v),
		.ss_act        (ss_act),
		.ss_we         (ss_we),
		.ss_addr       (ss_addr),
		.bank_sel      (bank_sel),
		.bank_dat_flat (bank_dat_flat),
		.mirror_v      (mirror_v),
		.mmc_ss_dat    (mmc_ss_dat)
	);

	chr_bank_map chr_bank_map_i
	(
		.ppu_addr      (ppu_addr[12:0]),
		.chr_mode      (bank_sel[7]),
		.bank_dat_flat (bank_dat_flat),
		.mirror_v      (mirror_v),
		.cfg_chr_ram   (cfg_chr_ram),
		.chr_addr      (chr_addr),
		.ciram_a10     (ciram_a10)
	);

	irq_mmc3
	#(
		.A12_FILTER (A12_FILTER)
	)
	irq_mmc3_i
	(
		.m2         (m2),
		.map_rst    (map_rst),
		.cpu_addr   (cpu_addr),
		.cpu_dat    (cpu_dat),
		.cpu_rw     (cpu_rw),
		.ppu_a12    (ppu_addr[12]),
		.mmc3a      (mmc3a),
		.ss_act     (ss_act),
		.ss_we      (ss_we),
		.ss_addr    (ss_addr),
		.irq        (irq),
		.irq_ss_dat (irq_ss_dat)
	);

endmodule

// ==== hdl/map_pkg.sv ====
package map_pkg;

	// CPU register addresses as seen after the A15-A13 and A0 decode
	localparam logic [15:0] REG_BANK_SEL   = 16'h8000;
	localparam logic [15:0] REG_BANK_DAT   = 16'h8001;
	localparam logic [15:0] REG_MIRROR     = 16'hA000;
	localparam logic [15:0] REG_RAM_CTRL   = 16'hA001;
	localparam logic [15:0] REG_IRQ_LATCH  = 16'hC000;
	localparam logic [15:0] REG_IRQ_RELOAD = 16'hC001;
	localparam logic [15:0] REG_IRQ_OFF    = 16'hE000;
	localparam logic [15:0] REG_IRQ_ON     = 16'hE001;

	localparam logic [15:0] PRG_WIN_LO = 16'h4120; // Inclusive
	localparam logic [15:0] PRG_WIN_HI = 16'h8000; // Exclusive

	localparam logic [7:0] SS_BANK_BASE = 8'd0; // Eight bank bytes
	localparam logic [7:0] SS_BANK_SEL  = 8'd8;
	localparam logic [7:0] SS_MIRROR    = 8'd9;
	localparam logic [7:0] SS_RAM_CTRL  = 8'd10;
	localparam logic [7:0] SS_IRQ_BASE  = 8'd16; // Eight IRQ slots
	localparam logic [7:0] SS_PRG       = 8'd32;
	localparam logic [7:0] SS_MAP_IDX   = 8'd127;

	localparam int BANK_NUM     = 8;
	localparam int PRG_PAGE_W   = 4;
	localparam int CHR_RAM_BITS = 5; // Bank bits kept with CHR RAM

	localparam logic [7:0] BANK_RESET [BANK_NUM] = '{
		8'd0,
		8'd2,
		8'd4,
		8'd5,
		8'd6,
		8'd7,
		8'd0,
		8'd1
	};

	localparam logic [PRG_PAGE_W-1:0] PRG_RESET = 4'hf;

	// Low m2 edges on A12 before a rise is counted
	localparam int A12_FILTER = 3;

endpackage

// ==== hdl/mmc3_regs.sv ====
`timescale 1ns/1ps

module mmc3_regs
(
	input  logic        m2,
	input  logic        map_rst,
	input  logic [15:0] cpu_addr,
	input  logic [7:0]  cpu_dat,
	input  logic        cpu_rw,
	input  logic        cfg_mir_v,
	input  logic        ss_act,
	input  logic        ss_we,
	input  logic [7:0]  ss_addr,
	output logic [7:0]  bank_sel,
	output logic [63:0] bank_dat_flat,
	output logic        mirror_v,
	output logic [7:0]  mmc_ss_dat
);

	import map_pkg::*;

	logic [7:0]  bank_dat [BANK_NUM];
	logic [7:0]  mir_reg;
	logic [7:0]  ram_ctrl; // Kept for save state only, PRG RAM is absent
	logic [15:0] reg_addr;
	logic        ss_bank_hit;

	assign reg_addr = {cpu_addr[15:13], 12'd0, cpu_addr[0]};
	assign ss_bank_hit = (ss_addr[7:3] == SS_BANK_BASE[7:3]);

	assign mirror_v = !mir_reg[0]; // Bit 0 low selects vertical

	always_ff @(negedge m2)
	begin
		if (ss_act)
		begin
			if (ss_we)
			begin
				if (ss_bank_hit)
					bank_dat[ss_addr[2:0]] <= cpu_dat;
				case (ss_addr)
					SS_BANK_SEL: bank_sel <= cpu_dat;
					SS_MIRROR:   mir_reg <= cpu_dat;
					SS_RAM_CTRL: ram_ctrl <= cpu_dat;
					default: ;
				endcase
			end
		end
		else if (map_rst)
		begin
			bank_sel <= 8'd0;
			mir_reg <= {7'd0, !cfg_mir_v};
			ram_ctrl <= 8'd0;
			for (int i = 0; i < BANK_NUM; i++)
				bank_dat[i] <= BANK_RESET[i];
		end
		else if (!cpu_rw)
		begin
			case (reg_addr)
				REG_BANK_SEL: bank_sel <= cpu_dat;
				REG_BANK_DAT: bank_dat[bank_sel[2:0]] <= cpu_dat; // Bank named by select
				REG_MIRROR:   mir_reg <= cpu_dat;
				REG_RAM_CTRL: ram_ctrl <= cpu_dat;
				default: ;
			endcase
		end
	end

	for (genvar i = 0; i < BANK_NUM; i++)
	begin : g_flat
		assign bank_dat_flat[8*i +: 8] = bank_dat[i];
	end

	always_comb
	begin
		if (ss_bank_hit)
			mmc_ss_dat = bank_dat[ss_addr[2:0]];
		else
		begin
			case (ss_addr)
				SS_BANK_SEL: mmc_ss_dat = bank_sel;
				SS_MIRROR:   mmc_ss_dat = mir_reg;
				SS_RAM_CTRL: mmc_ss_dat = ram_ctrl;
				default:     mmc_ss_dat = 8'hff;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator and run; the exit status is the verdict
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module tb_map_189 -o tb_map_189 &&
./obj_dir/tb_map_189 ||
{ echo "Simulation did not pass"; exit 1; }

// ==== test/map_189_chk.sv ====
`timescale 1ns/1ps

module map_189_chk
(
	input logic        m2,
	input logic        map_rst,
	input logic        ss_act,
	input logic [15:0] cpu_addr,
	input logic [13:0] ppu_addr,
	input logic [18:0] prg_addr,
	input logic        ciram_ce,
	input logic        irq,
	input logic        irq_on
);

	prg_low: assert property (@(negedge m2) prg_addr[14:0] == cpu_addr[14:0])
		else $error("PRG address bits 14 to 0 differ from the CPU address");

	ciram_sel: assert property (@(negedge m2) ciram_ce == !ppu_addr[13])
		else $error("ciram_ce is not the inverse of PPU A13");

	irq_reset: assert property (@(negedge m2) map_rst && !ss_act |=> !irq)
		else $error("irq is high in the cycle after reset");

	// A save-state load may restore a pending flag with the enable clear
	irq_enable: assert property (@(negedge m2) $rose(irq) |-> $past(irq_on || ss_act))
		else $error("irq rose while the IRQ enable was clear");

endmodule

bind map_189 map_189_chk map_189_chk_i
(
	.m2       (m2),
	.map_rst  (map_rst),
	.ss_act   (ss_act),
	.cpu_addr (cpu_addr),
	.ppu_addr (ppu_addr),
	.prg_addr (prg_addr),
	.ciram_ce (ciram_ce),
	.irq      (irq),
	.irq_on   (irq_mmc3_i.irq_on)
);

// ==== test/tb_map_189.sv ====
`timescale 1ns/1ps

module tb_map_189;

	import map_pkg::*;

	localparam int FILTER = A12_FILTER;
	localparam int WAIT_MAX = 20; // m2 cycles allowed for an IRQ to show up

	logic        m2, map_rst, cpu_rw, ppu_oe, ppu_we;
	logic        cfg_chr_ram, cfg_mir_v, ss_act, ss_we;
	logic [15:0] cpu_addr;
	logic [7:0]  cpu_dat, map_idx, ss_addr, ss_rdat;
	logic [13:0] ppu_addr;
	logic [3:0]  map_sub;
	logic [18:0] prg_addr;
	logic [17:0] chr_addr;
	logic        prg_oe, rom_ce, chr_oe, chr_ce, chr_we, ciram_a10, ciram_ce, irq;
	logic [7:0]  bank_tb [BANK_NUM]; // Bank bytes as written by the CPU
	logic [7:0]  ss_exp [0:32];
	int          seed = 59;

	map_189 #(.A12_FILTER(FILTER)) map_189_i (.*);

	initial
	begin
		m2 = 1'b0;
		forever
			#20 m2 = !m2;
	end

	task automatic stop_fail();
		$display("TEST FAILED");
		$fatal(1, "run stopped on the first failed check");
	endtask

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] got);
		assert (got == exp)
		else
		begin
			$display("ERR %s expected %0h actual %0h", name, exp, got);
			stop_fail();
		end
	endtask

	task automatic step();
		@(posedge m2);
		#2; // Inputs settle well before the falling edge
	endtask

	task automatic apply_reset(input logic mir_v);
		step();
		cfg_mir_v = mir_v;
		map_rst = 1'b1;
		repeat (4)
			step();
		map_rst = 1'b0;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] dat);
		step();
		cpu_addr = addr;
		cpu_dat = dat;
		cpu_rw = 1'b0;
		step();
		cpu_rw = 1'b1;
		cpu_addr = 16'h0000;
	endtask

	task automatic ppu_set(input logic [13:0] addr);
		step();
		ppu_addr = addr;
		#5;
	endtask

	// A12 low for some edges, high for exactly one, then low again
	task automatic a12_pulse(input int low_edges);
		repeat (low_edges)
		begin
			step();
			ppu_addr[12] = 1'b0;
		end
		step();
		ppu_addr[12] = 1'b1;
		step();
		ppu_addr[12] = 1'b0;
	endtask

	task automatic ss_write(input logic [7:0] addr, input logic [7:0] dat);
		step();
		ss_addr = addr;
		cpu_dat = dat; // Save-state data shares the CPU data bus
		ss_we = 1'b1;
		step();
		ss_we = 1'b0;
	endtask

	task automatic ss_read(input logic [7:0] addr, output logic [7:0] dat);
		step();
		ss_addr = addr;
		#5;
		dat = ss_rdat;
	endtask

	task automatic wait_irq();
		int n;
		n = 0;
		while (irq !== 1'b1 && n < WAIT_MAX)
		begin
			step();
			n++;
		end
		if (irq !== 1'b1)
		begin
			$display("Timeout: irq stayed low for %0d cycles", WAIT_MAX);
			stop_fail();
		end
	endtask

	// Horizontal mirroring follows A11, vertical follows A10
	task automatic check_mirror(input string name, input logic horiz);
		ppu_set(14'h0400);
		check_val(name, horiz ? 0 : 1, ciram_a10);
		ppu_set(14'h0800);
		check_val(name, horiz ? 1 : 0, ciram_a10);
	endtask

	// Chip enables and strobes on the CPU and PPU side
	task automatic check_strobes();
		step();
		cpu_addr = 16'h8000;
		ppu_addr = 14'h2000;
		ppu_oe = 1'b0;
		cfg_chr_ram = 1'b1;
		#5;
		check_val("rom_ce high", 1, rom_ce);
		check_val("prg_oe read", 1, prg_oe);
		check_val("chr_ce nametable", 0, chr_ce);
		check_val("chr_oe read", 1, chr_oe);
		check_val("chr_we idle", 0, chr_we);
		step();
		cpu_addr = 16'h0000;
		cpu_rw = 1'b0;
		ppu_addr = 14'h0000;
		ppu_oe = 1'b1;
		ppu_we = 1'b0;
		#5;
		check_val("rom_ce low", 0, rom_ce);
		check_val("prg_oe write", 0, prg_oe);
		check_val("chr_ce pattern", 1, chr_ce);
		check_val("chr_oe idle", 0, chr_oe);
		check_val("chr_we ram", 1, chr_we);
		step();
		cpu_rw = 1'b1;
		cfg_chr_ram = 1'b0;
		#5;
		check_val("chr_we rom", 0, chr_we);
		ppu_we = 1'b1;
	endtask

	function automatic logic [17:0] chr_expect(input logic [12:0] pa, input logic mode,
		input logic ram);
		logic [2:0] region;
		logic [7:0] bank;
		region = pa[12:10] ^ {mode, 2'b00}; // Mode 1 swaps the two 4 KB halves
		if (!region[2])
			bank = {bank_tb[region[1]][7:1], region[0]}; // 2 KB pair from banks 0 and 1
		else
			bank = bank_tb[2 + region[1:0]];
		if (ram)
			bank[7:5] = 3'b000;
		return {bank, pa[9:0]};
	endfunction

	function automatic bit ss_used(input int i);
		return i <= SS_RAM_CTRL || (i >= SS_IRQ_BASE && i <= SS_IRQ_BASE + 2) || i == SS_PRG;
	endfunction

	initial
	begin
		logic [7:0]  rd, b;
		logic [15:0] a;
		logic [3:0]  pg, pg_inv;
		int unsigned n;
		map_rst = 1'b1;
		cpu_addr = 16'h0000;
		cpu_dat = 8'h00;
		cpu_rw = 1'b1;
		ppu_addr = 14'h0000;
		ppu_oe = 1'b1;
		ppu_we = 1'b1;
		cfg_chr_ram = 1'b0;
		cfg_mir_v = 1'b1;
		map_sub = 4'd0;
		map_idx = 8'd189;
		ss_act = 1'b0;
		ss_we = 1'b0;
		ss_addr = 8'd0;

		apply_reset(1'b1);
		check_val("reset prg page", PRG_RESET, prg_addr[18:15]);
		for (int i = 0; i < BANK_NUM; i++)
		begin
			ss_read(SS_BANK_BASE + 8'(i), rd);
			check_val("reset bank", BANK_RESET[i], rd);
		end
		check_mirror("reset mirroring", 1'b0);
		apply_reset(1'b0);
		check_mirror("reset mirroring", 1'b1);
		check_strobes();

		b = 8'($random(seed)) | 8'h01; // Low bit set keeps the page off zero
		n = $unsigned($random(seed));
		a = PRG_WIN_LO + 16'(n % 32'(PRG_WIN_HI - PRG_WIN_LO));
		pg = b[7:4] | b[3:0];
		pg_inv = ~pg;
		cpu_write(PRG_WIN_LO, 8'h00);
		check_val("prg window bottom", 0, prg_addr[18:15]);
		cpu_write(a, b);
		check_val("prg page", pg, prg_addr[18:15]);
		cpu_write(16'h4100, {4'h0, pg_inv});
		cpu_write(PRG_WIN_HI, {4'h0, pg_inv});
		check_val("prg outside window", pg, prg_addr[18:15]);
		cpu_write(PRG_WIN_HI - 16'd1, {pg_inv, 4'h0});
		check_val("prg window top", pg_inv, prg_addr[18:15]);

		for (int i = 0; i < BANK_NUM; i++)
		begin
			bank_tb[i] = 8'($random(seed));
			cpu_write(REG_BANK_SEL, 8'(i));
			cpu_write(REG_BANK_DAT, bank_tb[i]);
		end
		for (int m = 0; m < 4; m++)
		begin
			cfg_chr_ram = m[1];
			cpu_write(REG_BANK_SEL, {m[0], 7'd0}); // Bit 7 is the CHR mode
			for (int r = 0; r < 8; r++)
			begin
				ppu_set({1'b0, r[2:0], 10'($random(seed))});
				check_val("chr address", chr_expect(ppu_addr[12:0], m[0], m[1]), chr_addr);
			end
		end
		cfg_chr_ram = 1'b0;

		cpu_write(REG_MIRROR, 8'h00);
		check_mirror("mirror vertical", 1'b0);
		cpu_write(REG_MIRROR, 8'h01);
		check_mirror("mirror horizontal", 1'b1);

		n = 1 + $unsigned($random(seed)) % 5;
		cpu_write(REG_IRQ_LATCH, 8'(n));
		cpu_write(REG_IRQ_RELOAD, 8'h00);
		cpu_write(REG_IRQ_ON, 8'h00);
		repeat (n)
			a12_pulse(FILTER); // First rise only loads the latch
		check_val("irq before last rise", 0, irq);
		a12_pulse(FILTER);
		wait_irq();
		cpu_write(REG_IRQ_OFF, 8'h00);
		check_val("irq acknowledge", 0, irq);

		cpu_write(REG_IRQ_LATCH, 8'd1);
		cpu_write(REG_IRQ_RELOAD, 8'h00);
		cpu_write(REG_IRQ_ON, 8'h00);
		a12_pulse(FILTER);
		a12_pulse(FILTER - 2); // One low edge short of the filter
		check_val("irq short a12 low", 0, irq);
		ss_read(SS_IRQ_BASE + 8'd1, rd);
		check_val("irq counter after short low", 1, rd);
		a12_pulse(FILTER);
		wait_irq();
		cpu_write(REG_IRQ_OFF, 8'h00);

		map_sub = 4'd4;
		cpu_write(REG_IRQ_LATCH, 8'd0);
		cpu_write(REG_IRQ_RELOAD, 8'h00);
		a12_pulse(FILTER); // Reload used up while IRQ is off
		cpu_write(REG_IRQ_ON, 8'h00);
		repeat (3)
			a12_pulse(FILTER);
		check_val("mmc3a latch 0", 0, irq);
		map_sub = 4'd0;
		a12_pulse(FILTER);
		wait_irq(); // Standard MMC3 fires on every rise at zero
		cpu_write(REG_IRQ_OFF, 8'h00);

		ss_act = 1'b1;
		for (int i = 0; i <= SS_PRG; i++)
		begin
			ss_exp[i] = 8'($random(seed));
			if (ss_used(i))
				ss_write(8'(i), ss_exp[i]);
		end
		ss_exp[SS_IRQ_BASE + 2] = ss_exp[SS_IRQ_BASE + 2] & 8'h07; // Three flag bits
		ss_exp[SS_PRG] = ss_exp[SS_PRG] & 8'h0f;
		cpu_write(REG_BANK_SEL, ~ss_exp[SS_BANK_SEL]);
		cpu_write(16'h6000, {4'h0, ~ss_exp[SS_PRG][3:0]});
		for (int i = 0; i <= SS_PRG; i++)
		begin
			if (ss_used(i))
			begin
				ss_read(8'(i), rd);
				check_val("save state readback", ss_exp[i], rd);
			end
		end
		ss_read(8'd11, rd);
		check_val("save state unmapped", 8'hff, rd);
		ss_read(8'd40, rd);
		check_val("save state unmapped", 8'hff, rd);
		ss_read(SS_MAP_IDX, rd);
		check_val("save state map index", map_idx, rd);
		ss_act = 1'b0;

		$display("TEST PASSED");
		$finish;
	end

endmodule
